//--- list.f
verilog/seq_pkg.sv
verilog/seq_cmd_if.sv
verilog/seq_cmd_table.sv
verilog/seq_state_fsm.sv
verilog/seq_dwell_timer.sv
verilog/seq_pointer.sv
verilog/sequencer_top.sv
test/tb_sequencer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_sequencer
FILELIST  := list.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_sequencer.sv
// Testbench for the panel drive sequencer, table load, command walk and exit redirect
module tb_sequencer;
    timeunit 1ns;
    timeprecision 1ps;
    import seq_pkg::*;

    localparam int ADDR_W     = 8;
    localparam int N_ENTRY    = 5;
    localparam int N_STEP     = 12;
    localparam int WAIT_LIMIT = 2000;           // Cycles allowed per wait

    logic                clk;
    logic                fsm_rst;
    logic                config_done_i;
    logic                lut_wen_i;
    logic [ADDR_W-1:0]   lut_addr_i;
    logic [CMD_W-1:0]    lut_wdata_i;
    logic [RPT_W-1:0]    expose_size_i;
    logic                exit_signal_i;
    logic                roic_even_odd_i;
    state_e              state_o;
    logic                busy_o;
    logic                readout_wait_o;
    logic                wait_o;
    logic                bias_o;
    logic                flush_o;
    logic                aed_o;
    logic                expose_o;
    logic                readout_o;
    logic                stv_mask_o;
    logic                csi_mask_o;
    logic                panel_stable_o;
    logic                sof_o;
    logic                eof_o;

    // Reference copy of the table
    state_e      tbl_state [N_ENTRY];
    int          tbl_len   [N_ENTRY];
    int          tbl_rpt   [N_ENTRY];
    int          tbl_nxt   [N_ENTRY];
    logic [4:0]  tbl_flags [N_ENTRY];           // stv, csi, panel, sof, eof
    int          expose_rpt;
    // Second frame ignores its exit, third falls through to entry 4
    int          walk_order [N_STEP] = '{0, 1, 2, 3, 1, 2, 3, 1, 2, 3, 4, 1};
    int          value_errs;
    int          other_errs;

    sequencer_top #(.ADDR_W(ADDR_W)) u_sequencer_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic value_error(input string name, input int got, input int exp);
        value_errs++;
        $display("error %0t %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic other_error(input string msg);
        other_errs++;
        $display("at %0t %s", $time, msg);
    endtask

    task automatic next_drive_point();
        @(posedge clk);
        #1;                                     // Inputs settle after the edge
    endtask

    function automatic logic [5:0] current_enables();
        return {wait_o, bias_o, flush_o, aed_o, expose_o, readout_o};
    endfunction

    // One-hot enable that a run state should drive
    function automatic logic [5:0] enable_of(input state_e s);
        case (s)
            WAIT:        return 6'b100000;
            BACK_BIAS:   return 6'b010000;
            FLUSH:       return 6'b001000;
            AED_DETECT:  return 6'b000100;
            EXPOSE_TIME: return 6'b000010;
            READOUT:     return 6'b000001;
            default:     return 6'b000000;
        endcase
    endfunction

    // (R+1)(L+1), expose uses the host repeat and eight times the length
    function automatic int dwell_cycles(input int idx);
        if (tbl_state[idx] == EXPOSE_TIME) begin
            return (expose_rpt + 1) * (8 * tbl_len[idx] + 1);
        end
        return (tbl_rpt[idx] + 1) * (tbl_len[idx] + 1);
    endfunction

    function automatic logic [CMD_W-1:0] build_entry(input int idx);
        logic [CMD_W-1:0] e;
        e = '0;
        e[LEN_LSB +: FLD_W]     = FLD_W'(tbl_len[idx]);
        e[RPT_LSB +: FLD_W]     = FLD_W'(tbl_rpt[idx]);
        e[NXT_LSB +: ADDR_W]    = ADDR_W'(tbl_nxt[idx]);
        e[STATE_LSB +: STATE_W] = tbl_state[idx];
        {e[STV_BIT], e[CSI_BIT], e[PANEL_BIT], e[SOF_BIT], e[EOF_BIT]} = tbl_flags[idx];
        return e;
    endfunction

    task automatic fill_table();
        tbl_state = '{WAIT, FLUSH, EXPOSE_TIME, READOUT, BACK_BIAS};
        tbl_nxt   = '{1, 2, 3, 1, 1};           // READOUT closes the frame
        tbl_flags = '{5'b10000, 5'b01110, 5'b11000, 5'b01001, 5'b00000};
        for (int i = 0; i < N_ENTRY; i++) begin
            tbl_len[i] = int'($urandom % 6);
            tbl_rpt[i] = int'($urandom % 4);
        end
        // Expose length nonzero and host repeat unlike the stored one
        tbl_len[2] = 1 + int'($urandom % 5);
        expose_rpt = (tbl_rpt[2] + 1 + int'($urandom % 3)) % 4;
    endtask

    // Outputs held quiet while the host owns the table
    task automatic check_config_outputs();
        assert (state_o == RST) else value_error("state_o", int'(state_o), int'(RST));
        assert (current_enables() == '0) else value_error("enables", int'(current_enables()), 0);
        assert (!busy_o) else value_error("busy_o", int'(busy_o), 0);
        assert (!readout_wait_o) else value_error("readout_wait_o", int'(readout_wait_o), 0);
    endtask

    // ------------------------------------------------------------------------
    // Command walk, sampled on the falling edge
    // ------------------------------------------------------------------------
    task automatic check_walk();
        int idx;
        int waited;
        int cycles;
        logic [4:0] flags;
        for (int step = 0; step < N_STEP; step++) begin
            idx    = walk_order[step];
            waited = 0;
            while (!busy_o && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!busy_o) begin
                other_error("timeout, no command started");
                return;
            end
            cycles = 0;
            while (busy_o && cycles <= WAIT_LIMIT) begin
                flags = {stv_mask_o, csi_mask_o, panel_stable_o, sof_o, eof_o};
                assert (current_enables() == enable_of(tbl_state[idx]))
                    else value_error("enables", int'(current_enables()),
                                     int'(enable_of(tbl_state[idx])));
                assert (flags == tbl_flags[idx])
                    else value_error("flags", int'(flags), int'(tbl_flags[idx]));
                cycles++;
                @(negedge clk);
            end
            assert (cycles == dwell_cycles(idx))
                else value_error("busy_o run length", cycles, dwell_cycles(idx));
            assert (current_enables() == '0)    // IDLE gap between commands
                else value_error("enables", int'(current_enables()), 0);
        end
    endtask

    task automatic pulse_exit_in(input state_e s);
        int waited;
        waited = 0;
        while (state_o != s && waited < WAIT_LIMIT) begin
            next_drive_point();
            waited++;
        end
        if (state_o != s) begin
            other_error("timeout, state for the exit pulse never came");
            return;
        end
        exit_signal_i = 1'b1;
        next_drive_point();
        exit_signal_i = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Exit pulses and ROIC gating, one readout per frame
    // ------------------------------------------------------------------------
    task automatic drive_controls();
        int waited;
        for (int frame = 0; frame < 3; frame++) begin
            if (frame > 0) begin
                pulse_exit_in(frame == 1 ? FLUSH : EXPOSE_TIME);   // Panel stable, then not
            end
            waited = 0;
            while (!readout_wait_o && waited < WAIT_LIMIT) begin
                next_drive_point();
                waited++;
            end
            if (!readout_wait_o) begin
                other_error("timeout, readout never waited for ROIC");
                return;
            end
            repeat (3) begin
                assert (readout_wait_o) else value_error("readout_wait_o", 0, 1);
                assert (!readout_o) else value_error("readout_o", 1, 0);
                next_drive_point();
            end
            roic_even_odd_i = 1'b1;
            waited = 0;
            while (!readout_o && waited < WAIT_LIMIT) begin
                next_drive_point();
                waited++;
            end
            if (!readout_o) begin
                other_error("timeout, readout did not start after ROIC rose");
            end
            roic_even_odd_i = 1'b0;             // Next frame stalls again
        end
    endtask

    initial begin
        void'($urandom(32'h205b));
        value_errs      = 0;
        other_errs      = 0;
        fsm_rst         = 1'b1;
        config_done_i   = 1'b1;
        lut_wen_i       = 1'b0;
        lut_addr_i      = '0;
        lut_wdata_i     = '0;
        exit_signal_i   = 1'b0;
        roic_even_odd_i = 1'b0;
        fill_table();
        expose_size_i   = RPT_W'(expose_rpt);
        repeat (16) begin
            @(negedge clk);
            check_config_outputs();
        end
        next_drive_point();
        fsm_rst = 1'b0;
        for (int i = 0; i < N_ENTRY; i++) begin
            lut_wen_i   = 1'b1;
            lut_addr_i  = ADDR_W'(i);
            lut_wdata_i = build_entry(i);
            next_drive_point();
        end
        lut_wen_i = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_config_outputs();             // Still RST after reset release
        end
        next_drive_point();
        config_done_i = 1'b0;
        fork
            check_walk();
            drive_controls();
        join
        $display("errors: %0d wrong value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/sequencer_top.sv
// Panel drive sequencer top, joins command table, pointer, dwell timer and FSM
module sequencer_top #(
    parameter int ADDR_W = 8
) (
    input  logic                        clk,
    input  logic                        fsm_rst,
    // Host table load
    input  logic                        config_done_i,
    input  logic                        lut_wen_i,
    input  logic [ADDR_W-1:0]           lut_addr_i,
    input  logic [seq_pkg::CMD_W-1:0]   lut_wdata_i,
    // Run controls
    input  logic [seq_pkg::RPT_W-1:0]   expose_size_i,
    input  logic                        exit_signal_i,
    input  logic                        roic_even_odd_i,
    // Status and enables
    output seq_pkg::state_e             state_o,
    output logic                        busy_o,
    output logic                        readout_wait_o,
    output logic                        wait_o,
    output logic                        bias_o,
    output logic                        flush_o,
    output logic                        aed_o,
    output logic                        expose_o,
    output logic                        readout_o,
    output logic                        stv_mask_o,
    output logic                        csi_mask_o,
    output logic                        panel_stable_o,
    output logic                        sof_o,
    output logic                        eof_o
);

    logic               load;                   // FSM start strobe
    logic               run;
    logic               dwell_end;
    logic [ADDR_W-1:0]  raddr;

    seq_cmd_if #(.ADDR_W(ADDR_W)) u_cmd_if ();

    // Writes only while the host owns the table
    seq_cmd_table #(.ADDR_W(ADDR_W)) u_cmd_table (
        .clk(clk), .wen_i(config_done_i & lut_wen_i), .waddr_i(lut_addr_i),
        .wdata_i(lut_wdata_i), .raddr_i(raddr), .cmd(u_cmd_if.tbl)
    );

    seq_pointer #(.ADDR_W(ADDR_W)) u_pointer (
        .clk(clk), .fsm_rst(fsm_rst), .config_done_i(config_done_i),
        .load_i(load), .exit_i(exit_signal_i), .cmd(u_cmd_if.user),
        .raddr_o(raddr)
    );

    seq_dwell_timer u_dwell_timer (
        .clk(clk), .fsm_rst(fsm_rst), .load_i(load), .run_i(run),
        .expose_size_i(expose_size_i), .cmd(u_cmd_if.user), .end_o(dwell_end)
    );

    seq_state_fsm u_state_fsm (
        .clk(clk), .fsm_rst(fsm_rst), .config_done_i(config_done_i),
        .roic_even_odd_i(roic_even_odd_i), .end_i(dwell_end),
        .cmd(u_cmd_if.user), .load_o(load), .run_o(run), .state_o(state_o),
        .busy_o(busy_o), .readout_wait_o(readout_wait_o),
        .wait_o(wait_o), .bias_o(bias_o), .flush_o(flush_o), .aed_o(aed_o),
        .expose_o(expose_o), .readout_o(readout_o),
        .stv_mask_o(stv_mask_o), .csi_mask_o(csi_mask_o),
        .panel_stable_o(panel_stable_o), .sof_o(sof_o), .eof_o(eof_o)
    );

endmodule

//--- verilog/seq_pointer.sv
// Table read pointer, follows entry links and redirects on a pending frame exit
module seq_pointer #(
    parameter int ADDR_W = 8
) (
    input  logic                clk,
    input  logic                fsm_rst,
    input  logic                config_done_i,  // Holds the walk at entry 0
    input  logic                load_i,         // Command starts
    input  logic                exit_i,         // Host exit request
    seq_cmd_if.user             cmd,
    output logic [ADDR_W-1:0]   raddr_o
);

    logic panel_q;                              // Running command is panel stable
    logic exit_pend;
    logic redirect;                             // Skip the stored link

    // EOF entry with a pending exit falls through to the next address
    assign redirect = load_i && cmd.eof && exit_pend;

    // ------------------------------------------------------------------------
    // Address register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge fsm_rst) begin
        if (fsm_rst) begin
            raddr_o <= '0;
            panel_q <= 1'b0;
        end else if (config_done_i) begin
            raddr_o <= '0;
            panel_q <= 1'b0;
        end else if (load_i) begin
            panel_q <= cmd.panel;
            if (redirect) begin
                raddr_o <= raddr_o + 1'b1;
            end else begin
                raddr_o <= cmd.next_addr;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Exit request, kept until the next end of frame
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge fsm_rst) begin
        if (fsm_rst) begin
            exit_pend <= 1'b0;
        end else if (config_done_i || redirect) begin
            exit_pend <= 1'b0;
        end else if (exit_i && !panel_q) begin
            exit_pend <= 1'b1;                  // Ignored while panel stable
        end
    end

endmodule

//--- verilog/seq_dwell_timer.sv
// Dwell length down-counter with repeat counter, end strobe on the last cycle
module seq_dwell_timer (
    input  logic                        clk,
    input  logic                        fsm_rst,
    input  logic                        load_i,         // From IDLE
    input  logic                        run_i,          // Command state active
    input  logic [seq_pkg::RPT_W-1:0]   expose_size_i,  // Expose repeat
    seq_cmd_if.user                     cmd,
    output logic                        end_o
);
    import seq_pkg::*;

    logic               is_expose;
    logic [LEN_W-1:0]   len_ld;                 // Length to load
    logic [RPT_W-1:0]   rpt_ld;                 // Repeat to load
    logic [LEN_W-1:0]   len_q;                  // Reload value per repeat
    logic [LEN_W-1:0]   dwell_q;
    logic [RPT_W-1:0]   rpt_q;
    logic               dwell_zero;

    // ------------------------------------------------------------------------
    // Load values
    // ------------------------------------------------------------------------
    assign is_expose = (cmd.state == EXPOSE_TIME);
    assign len_ld    = is_expose ? (LEN_W'(cmd.length) << EXPOSE_SHIFT)
                                 : LEN_W'(cmd.length);
    assign rpt_ld    = is_expose ? expose_size_i : RPT_W'(cmd.rpt);

    assign dwell_zero = (dwell_q == '0);
    assign end_o      = run_i && dwell_zero && (rpt_q == '0);   // Last cycle

    always_ff @(posedge clk) begin
        if (load_i) begin
            len_q <= len_ld;
        end
    end

    // ------------------------------------------------------------------------
    // Counters, (R+1)(L+1) run cycles per command
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge fsm_rst) begin
        if (fsm_rst) begin
            dwell_q <= '0;
            rpt_q   <= '0;
        end else if (load_i) begin
            dwell_q <= len_ld;
            rpt_q   <= rpt_ld;
        end else if (run_i) begin
            if (!dwell_zero) begin
                dwell_q <= dwell_q - 1'b1;
            end else if (rpt_q != '0) begin
                dwell_q <= len_q;               // Next repeat
                rpt_q   <= rpt_q - 1'b1;
            end
        end
    end

endmodule

//--- verilog/seq_state_fsm.sv
// Drive-state FSM, IDLE start decision, registered enables and panel flags
module seq_state_fsm (
    input  logic                clk,
    input  logic                fsm_rst,
    input  logic                config_done_i,      // Host owns the table
    input  logic                roic_even_odd_i,    // Readout may start
    input  logic                end_i,              // Dwell finished
    seq_cmd_if.user             cmd,
    output logic                load_o,             // Start strobe
    output logic                run_o,              // In a command state
    output seq_pkg::state_e     state_o,
    output logic                busy_o,
    output logic                readout_wait_o,
    output logic                wait_o,
    output logic                bias_o,
    output logic                flush_o,
    output logic                aed_o,
    output logic                expose_o,
    output logic                readout_o,
    output logic                stv_mask_o,
    output logic                csi_mask_o,
    output logic                panel_stable_o,
    output logic                sof_o,
    output logic                eof_o
);
    import seq_pkg::*;

    state_e state_q;
    state_e next_state;
    logic   stall;                              // Readout held off
    logic   stv_q, csi_q, panel_q, sof_q, eof_q;   // Flags of the loaded command

    assign stall   = (cmd.state == READOUT) && !roic_even_odd_i;
    assign run_o   = state_q inside {WAIT, BACK_BIAS, FLUSH, AED_DETECT,
                                     EXPOSE_TIME, READOUT};
    assign state_o = state_q;

    // ------------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge fsm_rst) begin
        if (fsm_rst) begin
            state_q <= RST;
        end else begin
            state_q <= next_state;
        end
    end

    // ------------------------------------------------------------------------
    // Next state and load strobe
    // ------------------------------------------------------------------------
    always_comb begin
        next_state = state_q;
        load_o     = 1'b0;
        if (config_done_i) begin
            next_state = RST;                   // Reconfig restarts the walk
        end else begin
            case (state_q)
                RST: next_state = IDLE;
                IDLE: begin
                    if (!stall) begin
                        load_o     = 1'b1;
                        next_state = cmd.state;
                    end
                end
                WAIT, BACK_BIAS, FLUSH, AED_DETECT, EXPOSE_TIME, READOUT: begin
                    if (end_i) begin
                        next_state = IDLE;
                    end
                end
                default: next_state = IDLE;     // Bad code from the table
            endcase
        end
    end

    // Command flags held for the whole dwell
    always_ff @(posedge clk) begin
        if (load_o) begin
            stv_q   <= cmd.stv;
            csi_q   <= cmd.csi;
            panel_q <= cmd.panel;
            sof_q   <= cmd.sof;
            eof_q   <= cmd.eof;
        end
    end

    // ------------------------------------------------------------------------
    // Registered outputs, one cycle behind state_o
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge fsm_rst) begin
        if (fsm_rst) begin
            {wait_o, bias_o, flush_o, aed_o, expose_o, readout_o} <= '0;
            {stv_mask_o, csi_mask_o, panel_stable_o, sof_o, eof_o} <= '0;
            busy_o         <= 1'b0;
            readout_wait_o <= 1'b0;
        end else begin
            wait_o         <= (state_q == WAIT);
            bias_o         <= (state_q == BACK_BIAS);
            flush_o        <= (state_q == FLUSH);
            aed_o          <= (state_q == AED_DETECT);
            expose_o       <= (state_q == EXPOSE_TIME);
            readout_o      <= (state_q == READOUT);
            busy_o         <= run_o;
            readout_wait_o <= (state_q == IDLE) && stall && !config_done_i;
            stv_mask_o     <= run_o && stv_q;   // Low between commands
            csi_mask_o     <= run_o && csi_q;
            panel_stable_o <= run_o && panel_q;
            sof_o          <= run_o && sof_q;
            eof_o          <= run_o && eof_q;
        end
    end

endmodule

//--- verilog/seq_cmd_table.sv
// Command table, host write port and zero latency read split into fields
module seq_cmd_table #(
    parameter int ADDR_W = 8
) (
    input  logic                        clk,
    input  logic                        wen_i,      // Host write strobe
    input  logic [ADDR_W-1:0]           waddr_i,
    input  logic [seq_pkg::CMD_W-1:0]   wdata_i,
    input  logic [ADDR_W-1:0]           raddr_i,    // From the pointer
    seq_cmd_if.tbl                      cmd
);
    import seq_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    logic [CMD_W-1:0] mem [DEPTH];          // Distributed RAM, no reset
    logic [CMD_W-1:0] entry;

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wen_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // ------------------------------------------------------------------------
    // Asynchronous read and decode
    // ------------------------------------------------------------------------
    assign entry = mem[raddr_i];

    // Out of range codes fall to IDLE in the FSM
    assign cmd.state     = state_e'(entry[STATE_LSB +: STATE_W]);
    assign cmd.length    = entry[LEN_LSB +: FLD_W];
    assign cmd.rpt       = entry[RPT_LSB +: FLD_W];
    assign cmd.next_addr = entry[NXT_LSB +: ADDR_W];   // Upper link bits unused below 8

    // Single bit flags
    assign cmd.eof       = entry[EOF_BIT];
    assign cmd.sof       = entry[SOF_BIT];
    assign cmd.stv       = entry[STV_BIT];
    assign cmd.csi       = entry[CSI_BIT];
    assign cmd.panel     = entry[PANEL_BIT];

endmodule

//--- verilog/seq_cmd_if.sv
// Decoded command entry, from the table to the FSM, timer and pointer
interface seq_cmd_if #(
    parameter int ADDR_W = 8
) ();
    import seq_pkg::*;

    state_e             state;              // Drive state of the entry
    logic [FLD_W-1:0]   length;             // Stored dwell length
    logic [FLD_W-1:0]   rpt;                // Stored repeat count
    logic [ADDR_W-1:0]  next_addr;          // Link to the next entry
    logic               sof;                // Start of frame
    logic               eof;                // End of frame
    logic               stv;
    logic               csi;
    logic               panel;              // Panel stable

    // Table side drives the fields
    modport tbl (
        output state, length, rpt, next_addr,
        output sof, eof, stv, csi, panel
    );

    // Consumers only read
    modport user (
        input  state, length, rpt, next_addr,
        input  sof, eof, stv, csi, panel
    );

endinterface

//--- verilog/seq_pkg.sv
// Sequencer package with drive states, table entry layout and counter widths
package seq_pkg;

    // ------------------------------------------------------------------------
    // Drive states
    // ------------------------------------------------------------------------
    localparam int STATE_W = 4;             // State field width in an entry

    typedef enum logic [STATE_W-1:0] {
        RST         = 4'd0,                 // Held while host configures
        WAIT        = 4'd1,
        BACK_BIAS   = 4'd2,
        FLUSH       = 4'd3,
        AED_DETECT  = 4'd4,
        EXPOSE_TIME = 4'd5,                 // Scaled length, host repeat
        READOUT     = 4'd6,                 // Gated by ROIC even/odd
        IDLE        = 4'd7                  // Fetch and start decision
    } state_e;

    // ------------------------------------------------------------------------
    // Table entry layout
    // ------------------------------------------------------------------------
    localparam int CMD_W     = 49;          // Full entry
    localparam int FLD_W     = 16;          // Stored length and repeat

    localparam int LEN_LSB   = 0;           // Length [15:0]
    localparam int RPT_LSB   = 16;          // Repeat [31:16]
    localparam int NXT_LSB   = 32;          // Link [39:32]
    localparam int STATE_LSB = 40;          // State [43:40]
    localparam int EOF_BIT   = 44;
    localparam int SOF_BIT   = 45;
    localparam int STV_BIT   = 46;          // STV mask, active high
    localparam int CSI_BIT   = 47;          // CSI mask
    localparam int PANEL_BIT = 48;          // Panel stable, blocks exit

    // ------------------------------------------------------------------------
    // Counter widths
    // ------------------------------------------------------------------------
    // Dwell counter holds a 16 bit length shifted for expose
    localparam int LEN_W        = 19;
    localparam int RPT_W        = 32;       // Matches expose_size_i
    localparam int EXPOSE_SHIFT = 3;        // x8

endpackage
